/* verilog/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	// machine word, doubles as the address width
	typedef logic [15:0] word_t;

	// top nibble of every instruction
	typedef enum logic [3:0] {
		OPC_BNE   = 4'd0,
		OPC_BEQ   = 4'd1,
		OPC_ADI   = 4'd4,
		OPC_LHI   = 4'd6,
		OPC_LWD   = 4'd7,
		OPC_SWD   = 4'd8,
		OPC_JMP   = 4'd9,
		OPC_RTYPE = 4'd15
	} opcode_e;

	// low six bits, only meaningful under rtype
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	// decoded operation carried down the pipe
	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_ORR,
		OP_ADI,
		OP_LHI,
		OP_LWD,
		OP_SWD,
		OP_BNE,
		OP_BEQ,
		OP_JMP,
		OP_WWD,
		OP_HLT
	} op_e;

	// unlisted encodings fall to the default arm of a case
	function automatic opcode_e inst_opcode(word_t inst);
		return opcode_e'(inst[15:12]);
	endfunction

	function automatic func_e inst_func(word_t inst);
		return func_e'(inst[5:0]);
	endfunction

	function automatic logic [1:0] inst_rs(word_t inst);
		return inst[11:10];
	endfunction

	function automatic logic [1:0] inst_rt(word_t inst);
		return inst[9:8];
	endfunction

	function automatic logic [1:0] inst_rd(word_t inst);
		return inst[7:6];
	endfunction

	// jump field, page bits come from the pc
	function automatic logic [11:0] inst_jtarget(word_t inst);
		return inst[11:0];
	endfunction

	// 8-bit immediate widened with its sign
	function automatic word_t sext_imm(word_t inst);
		return {{8{inst[7]}}, inst[7:0]};
	endfunction

endpackage

`default_nettype wire

/* verilog/cpu_pipe_pkg.sv */
`default_nettype none

package cpu_pipe_pkg;

	// one of the four architectural registers
	typedef logic [1:0] reg_idx_t;

	// control bits decided in decode, consumed downstream
	typedef struct packed {
		cpu_isa_pkg::op_e op;
		logic             reg_write;
		reg_idx_t         dest;
		logic             mem_read;
		logic             mem_write;
	} ctrl_t;

	// does nothing anywhere in the pipe
	localparam ctrl_t CTRL_NOP = '{
		op:        cpu_isa_pkg::OP_NOP,
		reg_write: 1'b0,
		dest:      2'd0,
		mem_read:  1'b0,
		mem_write: 1'b0
	};

	// in-flight instruction that will still write r
	function automatic logic writes_reg(logic valid, ctrl_t ctrl, reg_idx_t r);
		return valid && ctrl.reg_write && (ctrl.dest == r);
	endfunction

endpackage

`default_nettype wire

/* verilog/stage_link.sv */
`timescale 1ns/1ps
`default_nettype none

// one instruction slot between two adjacent stages
interface stage_link;
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic  valid;
	word_t pc;
	word_t inst;
	ctrl_t ctrl;
	// register operands, a is rs and b is rt
	word_t a;
	word_t b;
	word_t imm;
	// alu output, or load data after memory
	word_t result;

	modport producer (output valid, pc, inst, ctrl, a, b, imm, result);
	modport consumer (input valid, pc, inst, ctrl, a, b, imm, result);

	// hazard check only needs these two
	modport watch (input valid, ctrl);

endinterface

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter cpu_isa_pkg::word_t reset_pc = 16'h0000
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall,
	input wire logic redirect,
	input wire cpu_isa_pkg::word_t target,
	input wire cpu_isa_pkg::word_t data1,
	output cpu_isa_pkg::word_t address1,
	output logic read_m1,
	stage_link.producer if_id
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	word_t pc;
	logic halt_fetched;
	logic fetch_hlt;
	logic advance;

	// word on the instruction port is a halt
	assign fetch_hlt = (inst_opcode(data1) == OPC_RTYPE) && (inst_func(data1) == FN_HLT);

	// new word enters if/id this edge
	assign advance = !redirect && !stall && !halt_fetched;

	assign address1 = pc;
	assign read_m1 = ~halt_fetched;

	// decode fills these
	assign if_id.ctrl = CTRL_NOP;
	assign if_id.a = '0;
	assign if_id.b = '0;
	assign if_id.imm = '0;
	assign if_id.result = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
			halt_fetched <= 1'b0;
			if_id.valid <= 1'b0;
		end else if (redirect) begin
			// wrong-path word dropped, a flushed halt no longer counts
			pc <= target;
			halt_fetched <= 1'b0;
			if_id.valid <= 1'b0;
		end else if (advance) begin
			pc <= pc + 16'd1;
			halt_fetched <= fetch_hlt;
			if_id.valid <= 1'b1;
		end else if (!stall) begin
			// frozen behind a halt, feed bubbles
			if_id.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			if_id.pc <= pc;
			if_id.inst <= data1;
		end
	end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input wire logic clk,
	input wire logic rst,
	input wire logic redirect,
	input wire logic wb_we,
	input wire cpu_pipe_pkg::reg_idx_t wb_dest,
	input wire cpu_isa_pkg::word_t wb_data,
	output logic stall,
	stage_link.consumer if_id,
	stage_link.watch id_ex_watch,
	stage_link.watch ex_mem_watch,
	stage_link.watch mem_wb_watch,
	stage_link.producer id_ex
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	word_t regs [4];
	reg_idx_t rs;
	reg_idx_t rt;
	op_e op;
	ctrl_t ctrl;
	logic use_rs;
	logic use_rt;
	logic hit_rs;
	logic hit_rt;

	assign rs = inst_rs(if_id.inst);
	assign rt = inst_rt(if_id.inst);

	// opcode and func to one operation, empty slot is a nop
	always_comb begin
		op = OP_NOP;
		if (if_id.valid) begin
			case (inst_opcode(if_id.inst))
				OPC_BNE: op = OP_BNE;
				OPC_BEQ: op = OP_BEQ;
				OPC_ADI: op = OP_ADI;
				OPC_LHI: op = OP_LHI;
				OPC_LWD: op = OP_LWD;
				OPC_SWD: op = OP_SWD;
				OPC_JMP: op = OP_JMP;
				OPC_RTYPE: begin
					case (inst_func(if_id.inst))
						FN_ADD: op = OP_ADD;
						FN_SUB: op = OP_SUB;
						FN_AND: op = OP_AND;
						FN_ORR: op = OP_ORR;
						FN_WWD: op = OP_WWD;
						FN_HLT: op = OP_HLT;
						default: op = OP_NOP;
					endcase
				end
				default: op = OP_NOP;
			endcase
		end
	end

	// source fields the operation really reads
	always_comb begin
		use_rs = 1'b0;
		use_rt = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_BNE, OP_BEQ, OP_SWD: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			OP_ADI, OP_LWD, OP_WWD: use_rs = 1'b1;
			default: ;
		endcase
	end

	// rd for rtype, rt for immediate forms
	always_comb begin
		ctrl = CTRL_NOP;
		ctrl.op = op;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_ORR: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = inst_rd(if_id.inst);
			end
			OP_ADI, OP_LHI: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = rt;
			end
			OP_LWD: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = rt;
				ctrl.mem_read = 1'b1;
			end
			OP_SWD: ctrl.mem_write = 1'b1;
			default: ;
		endcase
	end

	// no forwarding, so wait until the writer has left writeback
	assign hit_rs = writes_reg(id_ex_watch.valid, id_ex_watch.ctrl, rs)
		|| writes_reg(ex_mem_watch.valid, ex_mem_watch.ctrl, rs)
		|| writes_reg(mem_wb_watch.valid, mem_wb_watch.ctrl, rs);
	assign hit_rt = writes_reg(id_ex_watch.valid, id_ex_watch.ctrl, rt)
		|| writes_reg(ex_mem_watch.valid, ex_mem_watch.ctrl, rt)
		|| writes_reg(mem_wb_watch.valid, mem_wb_watch.ctrl, rt);
	assign stall = (use_rs && hit_rs) || (use_rt && hit_rt);

	// register file, written by writeback at the edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// bubble on stall or on a taken branch behind us
	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex.valid <= if_id.valid && !stall && !redirect;
		end
	end

	always_ff @(posedge clk) begin
		id_ex.pc <= if_id.pc;
		id_ex.inst <= if_id.inst;
		id_ex.ctrl <= ctrl;
		id_ex.a <= regs[rs];
		id_ex.b <= regs[rt];
		id_ex.imm <= sext_imm(if_id.inst);
	end

	// execute computes this
	assign id_ex.result = '0;

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input wire logic clk,
	input wire logic rst,
	stage_link.consumer id_ex,
	stage_link.producer ex_mem,
	output logic redirect,
	output cpu_isa_pkg::word_t target
);
	import cpu_isa_pkg::*;

	word_t alu_out;
	logic taken;

	always_comb begin
		case (id_ex.ctrl.op)
			OP_ADD: alu_out = id_ex.a + id_ex.b;
			OP_SUB: alu_out = id_ex.a - id_ex.b;
			OP_AND: alu_out = id_ex.a & id_ex.b;
			OP_ORR: alu_out = id_ex.a | id_ex.b;
			// adi and the memory address share the adder
			OP_ADI, OP_LWD, OP_SWD: alu_out = id_ex.a + id_ex.imm;
			OP_LHI: alu_out = {id_ex.imm[7:0], 8'h00};
			// wwd and the rest just carry rs
			default: alu_out = id_ex.a;
		endcase
	end

	// branches compare rs with rt
	always_comb begin
		case (id_ex.ctrl.op)
			OP_BNE: taken = (id_ex.a != id_ex.b);
			OP_BEQ: taken = (id_ex.a == id_ex.b);
			OP_JMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// one cycle only, decode bubbles the next slot
	assign redirect = id_ex.valid && taken;

	// jmp keeps the pc page, branches are pc relative
	assign target = (id_ex.ctrl.op == OP_JMP)
		? {id_ex.pc[15:12], inst_jtarget(id_ex.inst)}
		: id_ex.pc + 16'd1 + id_ex.imm;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
		end else begin
			ex_mem.valid <= id_ex.valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem.pc <= id_ex.pc;
		ex_mem.inst <= id_ex.inst;
		ex_mem.ctrl <= id_ex.ctrl;
		ex_mem.a <= id_ex.a;
		ex_mem.b <= id_ex.b;
		ex_mem.imm <= id_ex.imm;
		ex_mem.result <= alu_out;
	end

endmodule

`default_nettype wire

/* verilog/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input wire logic clk,
	input wire logic rst,
	input wire cpu_isa_pkg::word_t data2_in,
	output logic read_m2,
	output logic write_m2,
	output cpu_isa_pkg::word_t address2,
	output cpu_isa_pkg::word_t data2_out,
	stage_link.consumer ex_mem,
	stage_link.producer mem_wb
);

	// strobes only for a live load or store
	assign read_m2 = ex_mem.valid && ex_mem.ctrl.mem_read;
	assign write_m2 = ex_mem.valid && ex_mem.ctrl.mem_write;

	// address from the alu, store data is rt
	assign address2 = ex_mem.result;
	assign data2_out = ex_mem.b;

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb.valid <= 1'b0;
		end else begin
			mem_wb.valid <= ex_mem.valid;
		end
	end

	always_ff @(posedge clk) begin
		mem_wb.pc <= ex_mem.pc;
		mem_wb.inst <= ex_mem.inst;
		mem_wb.ctrl <= ex_mem.ctrl;
		mem_wb.a <= ex_mem.a;
		mem_wb.b <= ex_mem.b;
		mem_wb.imm <= ex_mem.imm;
		// load data replaces the address
		mem_wb.result <= ex_mem.ctrl.mem_read ? data2_in : ex_mem.result;
	end

endmodule

`default_nettype wire

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
	input wire logic clk,
	input wire logic rst,
	stage_link.consumer mem_wb,
	output logic wb_we,
	output cpu_pipe_pkg::reg_idx_t wb_dest,
	output cpu_isa_pkg::word_t wb_data,
	output cpu_isa_pkg::word_t num_inst,
	output cpu_isa_pkg::word_t output_port,
	output logic is_halted
);
	import cpu_isa_pkg::*;

	logic live;

	// nothing retires once halted
	assign live = mem_wb.valid && !is_halted;

	// register file port, taken at the edge ending this cycle
	assign wb_we = live && mem_wb.ctrl.reg_write;
	assign wb_dest = mem_wb.ctrl.dest;
	assign wb_data = mem_wb.result;

	always_ff @(posedge clk) begin
		if (rst) begin
			num_inst <= '0;
			output_port <= '0;
			is_halted <= 1'b0;
		end else if (live) begin
			num_inst <= num_inst + 16'd1;
			// wwd shows rs
			if (mem_wb.ctrl.op == OP_WWD) begin
				output_port <= mem_wb.a;
			end
			if (mem_wb.ctrl.op == OP_HLT) begin
				is_halted <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter cpu_isa_pkg::word_t reset_pc = 16'h0000
) (
	input wire logic clk,
	input wire logic rst,
	output logic read_m1,
	output cpu_isa_pkg::word_t address1,
	input wire cpu_isa_pkg::word_t data1,
	output logic read_m2,
	output logic write_m2,
	output cpu_isa_pkg::word_t address2,
	output cpu_isa_pkg::word_t data2_out,
	input wire cpu_isa_pkg::word_t data2_in,
	output cpu_isa_pkg::word_t num_inst,
	output cpu_isa_pkg::word_t output_port,
	output logic is_halted
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	// hazard hold, decode to fetch
	logic stall;
	// taken branch or jump from execute
	logic redirect;
	word_t target;
	// register write port from writeback
	logic wb_we;
	reg_idx_t wb_dest;
	word_t wb_data;

	stage_link if_id ();
	stage_link id_ex ();
	stage_link ex_mem ();
	stage_link mem_wb ();

	fetch_stage #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.data1(data1),
		.address1(address1),
		.read_m1(read_m1),
		.if_id(if_id)
	);

	// id_ex goes in twice, as output and as hazard source
	decode_stage u_decode (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.wb_we(wb_we),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.stall(stall),
		.if_id(if_id),
		.id_ex_watch(id_ex),
		.ex_mem_watch(ex_mem),
		.mem_wb_watch(mem_wb),
		.id_ex(id_ex)
	);

	execute_stage u_execute (
		.clk(clk),
		.rst(rst),
		.id_ex(id_ex),
		.ex_mem(ex_mem),
		.redirect(redirect),
		.target(target)
	);

	memory_stage u_memory (
		.clk(clk),
		.rst(rst),
		.data2_in(data2_in),
		.read_m2(read_m2),
		.write_m2(write_m2),
		.address2(address2),
		.data2_out(data2_out),
		.ex_mem(ex_mem),
		.mem_wb(mem_wb)
	);

	writeback_stage u_writeback (
		.clk(clk),
		.rst(rst),
		.mem_wb(mem_wb),
		.wb_we(wb_we),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

endmodule

`default_nettype wire

/* sim/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
	input wire logic clk,
	input wire logic rst,
	input wire logic read_m2,
	input wire logic write_m2,
	input wire logic is_halted,
	input wire cpu_isa_pkg::word_t num_inst
);

	// single data port, one direction per cycle
	a_one_access: assert property (@(posedge clk) disable iff (rst) !(read_m2 && write_m2))
		else $error("read_m2 and write_m2 high in the same cycle");

	// only reset may clear the halt latch
	a_halt_holds: assert property (@(posedge clk) (is_halted && !rst) |=> is_halted)
		else $error("is_halted fell without reset");

	// nothing retires after halt
	a_count_frozen: assert property (@(posedge clk) disable iff (rst)
		is_halted |=> $stable(num_inst))
		else $error("num_inst changed while halted");

	a_no_store: assert property (@(posedge clk) disable iff (rst) is_halted |-> !write_m2)
		else $error("write_m2 high while halted");

endmodule

bind cpu_top cpu_checker u_checker (
	.clk(clk),
	.rst(rst),
	.read_m2(read_m2),
	.write_m2(write_m2),
	.is_halted(is_halted),
	.num_inst(num_inst)
);

`default_nettype wire

/* sim/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import cpu_isa_pkg::*;

	logic clk;
	logic rst;
	logic read_m1;
	word_t address1;
	word_t data1;
	logic read_m2;
	logic write_m2;
	word_t address2;
	word_t data2_out;
	word_t data2_in;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	// 256-word instruction and data memories
	word_t imem [256];
	word_t dmem [256];
	// data image copied into dmem while reset is high
	word_t dmem_init [256];

	// expected values from the stimulus file
	word_t exp_out [$];
	word_t exp_mem_addr [$];
	word_t exp_mem_data [$];
	word_t exp_retired;
	int prog_words;

	// owned by the output monitor
	int out_errors = 0;
	int out_idx = 0;
	word_t last_out = '0;

	// owned by the main sequence
	int retire_errors;
	int mem_errors;
	int flag_errors;
	int other_errors;

	// timeout bookkeeping
	int cycle_count;
	int cycle_limit;

	cpu_top #(
		.reset_pc(16'h0000)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.read_m1(read_m1),
		.address1(address1),
		.data1(data1),
		.read_m2(read_m2),
		.write_m2(write_m2),
		.address2(address2),
		.data2_out(data2_out),
		.data2_in(data2_in),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	// both memories answer within the cycle
	assign data1 = imem[address1[7:0]];
	assign data2_in = dmem[address2[7:0]];

	// image loaded during reset, stores land on the edge
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= dmem_init[i];
			end
		end else if (write_m2) begin
			dmem[address2[7:0]] <= data2_out;
		end
	end

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic check_output(word_t got, word_t exp);
		if (got !== exp) begin
			out_errors++;
			$display("[FAIL] %0t: output_port is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_retired(word_t got, word_t exp);
		if (got !== exp) begin
			retire_errors++;
			$display("[FAIL] %0t: num_inst is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_memory(word_t addr, word_t got, word_t exp);
		if (got !== exp) begin
			mem_errors++;
			$display("[FAIL] %0t: dmem[%h] is %h, expected %h", $time, addr, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			flag_errors++;
			$display("[FAIL] %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// fills both memories, then reads tagged lines
	task automatic load_stimulus();
		int fd;
		int code;
		int ch;
		logic [7:0] tag;
		word_t value;
		word_t addr;
		for (int i = 0; i < 256; i++) begin
			// opcode 2 is unused, so stray fetches retire as no-ops
			imem[i] = {4'h2, 4'h0, i[7:0]};
			dmem_init[i] = 16'hd000 | 16'(i);
		end
		prog_words = 0;
		fd = $fopen("sim/program_stimulus.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open sim/program_stimulus.txt");
			return;
		end
		code = $fscanf(fd, "%s", tag);
		while (code == 1) begin
			case (tag)
				"#": begin
					// rest of the line is a remark
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1) begin
						ch = $fgetc(fd);
					end
				end
				"I": begin
					code = $fscanf(fd, "%h %h", value, addr);
					imem[addr[7:0]] = value;
					prog_words++;
				end
				"D": begin
					code = $fscanf(fd, "%h %h", value, addr);
					dmem_init[addr[7:0]] = value;
				end
				"M": begin
					code = $fscanf(fd, "%h %h", value, addr);
					exp_mem_data.push_back(value);
					exp_mem_addr.push_back(addr);
				end
				"O": begin
					code = $fscanf(fd, "%h", value);
					exp_out.push_back(value);
				end
				"N": begin
					code = $fscanf(fd, "%h", exp_retired);
				end
				default: begin
					other_errors++;
					$display("unknown tag in the stimulus file");
				end
			endcase
			code = $fscanf(fd, "%s", tag);
		end
		$fclose(fd);
	endtask

	// each change of output_port consumes the next expected value
	always @(negedge clk) begin
		if (rst === 1'b0 && output_port !== last_out) begin
			if (out_idx >= exp_out.size()) begin
				out_errors++;
				$display("[FAIL] %0t: output_port changed to %h, nothing left to expect",
					$time, output_port);
			end else begin
				check_output(output_port, exp_out[out_idx]);
			end
			out_idx++;
			last_out = output_port;
		end
	end

	// limit grows with program length
	initial begin
		cycle_count = 0;
		@(negedge rst);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the core never halted", cycle_limit);
		$display("Something failed");
		$finish;
	end

	initial begin
		word_t addr;
		int total;
		rst = 1'b1;
		retire_errors = 0;
		mem_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		load_stimulus();
		cycle_limit = 20 * prog_words + 100;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		// first fetch completes on the next rising edge
		@(negedge clk);
		check_flag("read_m1", read_m1, 1'b1);
		check_flag("read_m2", read_m2, 1'b0);
		check_flag("write_m2", write_m2, 1'b0);
		check_flag("is_halted", is_halted, 1'b0);
		check_retired(num_inst, 16'h0000);
		check_output(output_port, 16'h0000);
		while (is_halted !== 1'b1) begin
			@(negedge clk);
		end
		// fetch stays frozen behind the halt
		check_flag("read_m1", read_m1, 1'b0);
		// count must hold once halted
		check_retired(num_inst, exp_retired);
		repeat (10) begin
			@(negedge clk);
			check_retired(num_inst, exp_retired);
		end
		for (int i = 0; i < exp_mem_addr.size(); i++) begin
			addr = exp_mem_addr[i];
			check_memory(addr, dmem[addr[7:0]], exp_mem_data[i]);
		end
		if (out_idx < exp_out.size()) begin
			other_errors++;
			$display("%0d expected output values never appeared", exp_out.size() - out_idx);
		end
		total = out_errors + retire_errors + mem_errors + flag_errors + other_errors;
		$display("errors: output %0d, retired %0d, memory %0d, flags %0d, other %0d",
			out_errors, retire_errors, mem_errors, flag_errors, other_errors);
		if (total == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/program_stimulus.txt */
# columns: tag value [address], all hex; I instruction, D initial data, M final data
# O next output_port value, N final num_inst; text after a lone # is a remark
I 4105 00 # adi r1 = r0 + 5
I F41C 01
O 0005
I 6212 02 # lhi r2 = 12 << 8
I F81C 03
O 1200
I F6C0 04 # add r3 = r1 + r2
I FC1C 05
O 1205
I FDC1 06 # sub r3 = r3 - r1
I FC1C 07
O 1200
I 45FD 08 # adi r1 = r1 - 3
I F41C 09
O 0002
I 633C 0A
I 4F5A 0B
I FE82 0C # and r2 = r3 & r2
I F81C 0D
O 1000
I F643 0E # orr r1 = r1 | r2
I F41C 0F
O 1002
I 4103 10 # dependent chain with no gap
I F580 11
I F9C0 12
I FC1C 13
O 0009
I 6155 14 # clobber r1 to r3
I 6266 15
I 6377 16
I FC1C 17
O 7700
I 4103 18 # same chain, three no-ops between steps
I 2019 19
I 201A 1A
I 201B 1B
I F580 1C
I 201D 1D
I 201E 1E
I 201F 1F
I F9C0 20
I 2021 21
I 2022 22
I 2023 23
I FC1C 24
O 0009
I 62AB 25 # store then load the same word
I 4A34 26
I 8240 27
I 7340 28
I FC1C 29
O AB34
I 4150 2A
I 7601 2B # lwd r2 = mem[r1 + 1]
I 86FF 2C # swd mem[r1 - 1] = r2
I 7700 2D
I FEC0 2E
I FC1C 2F
O 0BF1
I 1002 30 # beq taken to 33
I F41C 31
I F81C 32
I 0401 33 # bne taken to 35
I F41C 34
I 0005 35 # bne not taken
I 1405 36 # beq not taken
I F41C 37
O 0050
I 903B 38 # jmp over a wwd and a halt
I F81C 39
I F01D 3A
I 4203 3B # countdown loop
I 4AFF 3C
I F81C 3D
I 08FD 3E
O 0002
O 0001
O 0000
I 4380 3F # negative immediate
I FC1C 40
O FF80
I F01D 41
D 0123 50
D 0ACE 51
N 0043
M AB34 40
M 0ACE 4F
M 0123 50
M 0ACE 51

/* flist.f */
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/stage_link.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/cpu_top.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

/* Makefile */
SRCS := $(wildcard verilog/*.sv sim/*.sv)

.PHONY: run clean

run: obj_dir/Vcpu_tb
	@out="$$(./obj_dir/Vcpu_tb)"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

obj_dir/Vcpu_tb: flist.f $(SRCS)
	verilator --binary -j 0 --assert --timescale 1ns/1ps --top-module cpu_tb -f flist.f -Mdir obj_dir

clean:
	rm -rf obj_dir
